//--- common/macPkg.sv
////////////////////
// Shared constants and types of the bit-serial matrix MAC engine
// Digit size, counter widths, accumulator type and sequencer states
////////////////////

package macPkg;

    // Bits handled per serial step
    localparam int DigitBits = 2;

    // Digit counts and indices up to a 16-bit operand, plus the column range
    localparam int DigitCountBits = 4;

    // Width of C, D and the running result
    localparam int AccBits = 32;

    // Bit offset of an output digit inside the accumulator
    localparam int ShiftBits = 5;

    // One digit of an operand or of a partial product
    typedef logic [DigitBits-1:0] digit_t;

    // Digit count, digit index or output column
    typedef logic [DigitCountBits-1:0] digitCount_t;

    // Accumulator, C entry or D entry
    typedef logic [AccBits-1:0] acc_t;

    // Shift applied to a summed digit before it is added
    typedef logic [ShiftBits-1:0] shiftAmt_t;

    // Idle waits for a job, Run walks the digit pairs, Final emits the top
    // digit and Hold presents the result until it is taken
    typedef enum logic [1:0] {
        Idle,
        Run,
        Final,
        Hold
    } seqState_t;

endpackage

//--- hw/sequencer/digitSequencer.sv
////////////////////
// Digit sequencer
// Walks the output columns and the digit pairs of each column, drives the
// digit selects, sign correction flags and both handshakes
////////////////////

`timescale 1ns/100ps

module digitSequencer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  macPkg::digitCount_t bitSizeA_i,
    input  macPkg::digitCount_t bitSizeB_i,
    input  logic                valid_i,
    input  logic                ready_i,
    output logic                ready_o,
    output logic                valid_o,
    output logic                start_o,
    output logic                newDigit_o,
    output logic                finalDigit_o,
    output logic                lastDigit_o,
    output logic                placeOne_o,
    output logic                invertA_o,
    output logic                invertB_o,
    output macPkg::digitCount_t selA_o,
    output macPkg::digitCount_t selB_o,
    output macPkg::shiftAmt_t   shift_o
);
    import macPkg::*;

    seqState_t   state;
    digitCount_t sizeA;
    digitCount_t sizeB;

    // Output column, pair index inside the column and lowest A digit of the column
    digitCount_t colCount;
    digitCount_t pairCount;
    digitCount_t lowOffset;

    digitCount_t highA;
    digitCount_t lastCol;
    digitCount_t nextLow;
    digitCount_t selA;
    digitCount_t selB;
    logic        lastPair;
    logic        accept;

    assign accept  = valid_i & ready_o;
    assign ready_o = (state == Idle) | ((state == Hold) & ready_i);
    assign valid_o = state == Hold;
    assign start_o = accept;

    // The last column with digit pairs; the column after it only holds carries
    assign lastCol = sizeA + sizeB - digitCount_t'(2);

    // Pairs of column c use A digits from max(0, c-sizeB+1) to min(c, sizeA-1)
    assign highA   = (colCount < sizeA) ? colCount : sizeA - digitCount_t'(1);
    assign nextLow = (colCount >= sizeB - digitCount_t'(1)) ?
                     colCount + digitCount_t'(2) - sizeB : '0;

    assign selA     = lowOffset + pairCount;
    assign selB     = colCount - selA;
    assign lastPair = selA == highA;

    // In the top column both selects point past any operand, so the multipliers
    // see zero digits there and only pass on their carry
    assign selA_o = (state == Run) ? selA : '1;
    assign selB_o = (state == Run) ? selB : '1;

    // The sign digit of an operand inverts its cross terms
    assign invertA_o = (state == Run) & (selA == sizeA - digitCount_t'(1));
    assign invertB_o = (state == Run) & (selB == sizeB - digitCount_t'(1));

    assign lastDigit_o  = ((state == Run) & lastPair) | (state == Final);
    assign newDigit_o   = lastDigit_o;
    assign finalDigit_o = state == Final;

    // Correction one at the top bit of the product
    assign placeOne_o = state == Final;

    assign shift_o = {colCount, 1'b0};

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state     <= Idle;
            sizeA     <= '0;
            sizeB     <= '0;
            colCount  <= '0;
            pairCount <= '0;
            lowOffset <= '0;
        end else begin
            case (state)
                Idle, Hold: begin
                    if (accept) begin
                        state     <= Run;
                        sizeA     <= bitSizeA_i;
                        sizeB     <= bitSizeB_i;
                        colCount  <= '0;
                        pairCount <= '0;
                        lowOffset <= '0;
                    end else if (state == Hold && ready_i) begin
                        state <= Idle;
                    end
                end
                Run: begin
                    if (lastPair) begin
                        pairCount <= '0;
                        colCount  <= colCount + digitCount_t'(1);
                        lowOffset <= nextLow;
                        if (colCount == lastCol) begin
                            state <= Final;
                        end
                    end else begin
                        pairCount <= pairCount + digitCount_t'(1);
                    end
                end
                Final: begin
                    state <= Hold;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

endmodule

//--- hw/multiplier/serialMult.sv
////////////////////
// Serial element multiplier
// Forms one two-bit digit pair product per cycle with modified Baugh-Wooley
// sign handling and emits the product one output digit per column
////////////////////

`timescale 1ns/100ps

module serialMult #(
    parameter int MaxWidth = 16
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [MaxWidth-1:0] a_i,
    input  logic [MaxWidth-1:0] b_i,
    input  macPkg::digitCount_t selA_i,
    input  macPkg::digitCount_t selB_i,
    input  logic                invertA_i,
    input  logic                invertB_i,
    input  logic                placeOne_i,
    input  logic                start_i,
    input  logic                lastDigit_i,
    output macPkg::digit_t      prod_o
);
    import macPkg::*;

    localparam int Digits = MaxWidth / DigitBits;

    // Column sums stay below 20 per digit of the wider operand
    localparam int CarryBits = $clog2(32 * Digits);

    typedef logic [CarryBits-1:0] carry_t;

    logic [MaxWidth-1:0] aReg;
    logic [MaxWidth-1:0] bReg;
    digit_t digitA;
    digit_t digitB;
    logic   t00;
    logic   t01;
    logic   t10;
    logic   t11;
    carry_t term;
    carry_t corr;
    carry_t carry;
    carry_t colSum;

    // Operands are captured at acceptance so the inputs may move on
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            aReg <= a_i;
            bReg <= b_i;
        end
    end

    // Selects beyond the operand return a zero digit
    always_comb begin
        digitA = '0;
        digitB = '0;
        for (int d = 0; d < Digits; d++) begin
            if (selA_i == digitCount_t'(d)) begin
                digitA = aReg[DigitBits*d +: DigitBits];
            end
            if (selB_i == digitCount_t'(d)) begin
                digitB = bReg[DigitBits*d +: DigitBits];
            end
        end
    end

    // Bit products against exactly one sign bit are inverted
    assign t00 = digitA[0] & digitB[0];
    assign t01 = (digitA[0] & digitB[1]) ^ invertB_i;
    assign t10 = (digitA[1] & digitB[0]) ^ invertA_i;
    assign t11 = (digitA[1] & digitB[1]) ^ (invertA_i ^ invertB_i);

    assign term = carry_t'(t00) + carry_t'({t01, 1'b0}) + carry_t'({t10, 1'b0})
                + carry_t'({t11, 2'b00});

    // The first cell of each sign row carries that row's correction one,
    // the top correction one arrives with placeOne_i
    always_comb begin
        corr = '0;
        if (invertA_i && selB_i == '0) begin
            corr = corr + carry_t'(2);
        end
        if (invertB_i && selA_i == '0) begin
            corr = corr + carry_t'(2);
        end
        if (placeOne_i) begin
            corr = corr + carry_t'(2);
        end
    end

    assign colSum = carry + term + corr;
    assign prod_o = colSum[DigitBits-1:0];

    // Within a column the pair terms pile up, at its end the overflow moves on
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            carry <= '0;
        end else if (start_i) begin
            carry <= '0;
        end else if (lastDigit_i) begin
            carry <= colSum >> DigitBits;
        end else begin
            carry <= colSum;
        end
    end

endmodule

//--- hw/multiplier/digitAdderTree.sv
////////////////////
// Digit adder tree
// Sums the K product digits of one output cell in a balanced tree
////////////////////

`timescale 1ns/100ps

module digitAdderTree #(
    parameter int K = 2
) (
    input  macPkg::digit_t [K-1:0]                      digits_i,
    input  logic                                        signedSum_i,
    output logic [macPkg::DigitBits+$clog2(K)-1:0]      sum_o
);
    import macPkg::*;

    localparam int SumBits = DigitBits + $clog2(K);
    localparam int Levels  = $clog2(K);
    localparam int Leaves  = 1 << Levels;

    typedef logic [SumBits-1:0] node_t;

    // Heap layout with the root at index 0 and leaves at the end
    node_t node [2*Leaves-1];

    always_comb begin
        for (int i = 0; i < Leaves; i++) begin
            if (i >= K) begin
                node[Leaves-1+i] = '0;
            end else if (signedSum_i) begin
                // Top digit of every product is a two's complement digit
                node[Leaves-1+i] = node_t'($signed(digits_i[i]));
            end else begin
                node[Leaves-1+i] = node_t'(digits_i[i]);
            end
        end
        for (int n = Leaves - 2; n >= 0; n--) begin
            node[n] = node[2*n+1] + node[2*n+2];
        end
    end

    assign sum_o = node[0];

endmodule

//--- hw/result/cellAccumulator.sv
////////////////////
// Cell accumulator
// Starts from the C entry and adds each summed digit at its bit offset
////////////////////

`timescale 1ns/100ps

module cellAccumulator #(
    parameter int K = 2
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   start_i,
    input  logic                                   newDigit_i,
    input  logic                                   finalDigit_i,
    input  macPkg::acc_t                           c_i,
    input  macPkg::shiftAmt_t                      shift_i,
    input  logic [macPkg::DigitBits+$clog2(K)-1:0] sum_i,
    output macPkg::acc_t                           d_o
);
    import macPkg::*;

    acc_t accReg;
    acc_t sumExt;

    // Only the top digit column is signed, all lower columns are magnitudes
    always_comb begin
        if (finalDigit_i) begin
            sumExt = acc_t'($signed(sum_i));
        end else begin
            sumExt = acc_t'(sum_i);
        end
    end

    // Wrap-around addition keeps D modulo 2^32
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            accReg <= '0;
        end else if (start_i) begin
            accReg <= c_i;
        end else if (newDigit_i) begin
            accReg <= accReg + (sumExt << shift_i);
        end
    end

    assign d_o = accReg;

endmodule

//--- hw/matMacTop.sv
////////////////////
// Matrix MAC top
// Computes D = A*B + C bit-serially over an M x N grid of cells
////////////////////

`timescale 1ns/100ps

module matMacTop #(
    parameter int M        = 2,
    parameter int N        = 2,
    parameter int K        = 2,
    parameter int MaxWidth = 16
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [M-1:0][K-1:0][MaxWidth-1:0]   a_i,
    input  logic [K-1:0][N-1:0][MaxWidth-1:0]   b_i,
    input  macPkg::acc_t [M-1:0][N-1:0]         c_i,
    input  macPkg::digitCount_t                 bitSizeA_i,
    input  macPkg::digitCount_t                 bitSizeB_i,
    input  logic                                valid_i,
    output logic                                ready_o,
    output logic                                valid_o,
    input  logic                                ready_i,
    output macPkg::acc_t [M-1:0][N-1:0]         d_o
);
    import macPkg::*;

    localparam int SumBits = DigitBits + $clog2(K);

    logic        start;
    logic        newDigit;
    logic        finalDigit;
    logic        lastDigit;
    logic        placeOne;
    logic        invertA;
    logic        invertB;
    digitCount_t selA;
    digitCount_t selB;
    shiftAmt_t   shift;

    digitSequencer u_digitSequencer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bitSizeA_i   (bitSizeA_i),
        .bitSizeB_i   (bitSizeB_i),
        .valid_i      (valid_i),
        .ready_i      (ready_i),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .start_o      (start),
        .newDigit_o   (newDigit),
        .finalDigit_o (finalDigit),
        .lastDigit_o  (lastDigit),
        .placeOne_o   (placeOne),
        .invertA_o    (invertA),
        .invertB_o    (invertB),
        .selA_o       (selA),
        .selB_o       (selB),
        .shift_o      (shift)
    );

    for (genvar r = 0; r < M; r++) begin : gen_row
        for (genvar c = 0; c < N; c++) begin : gen_col
            digit_t [K-1:0]     prods;
            logic [SumBits-1:0] cellSum;

            // One multiplier per term of the dot product
            for (genvar k = 0; k < K; k++) begin : gen_term
                serialMult #(
                    .MaxWidth (MaxWidth)
                ) u_serialMult (
                    .clk_i       (clk_i),
                    .rst_ni      (rst_ni),
                    .a_i         (a_i[r][k]),
                    .b_i         (b_i[k][c]),
                    .selA_i      (selA),
                    .selB_i      (selB),
                    .invertA_i   (invertA),
                    .invertB_i   (invertB),
                    .placeOne_i  (placeOne),
                    .start_i     (start),
                    .lastDigit_i (lastDigit),
                    .prod_o      (prods[k])
                );
            end

            digitAdderTree #(
                .K (K)
            ) u_digitAdderTree (
                .digits_i    (prods),
                .signedSum_i (finalDigit),
                .sum_o       (cellSum)
            );

            cellAccumulator #(
                .K (K)
            ) u_cellAccumulator (
                .clk_i        (clk_i),
                .rst_ni       (rst_ni),
                .start_i      (start),
                .newDigit_i   (newDigit),
                .finalDigit_i (finalDigit),
                .c_i          (c_i[r][c]),
                .shift_i      (shift),
                .sum_i        (cellSum),
                .d_o          (d_o[r][c])
            );
        end
    end

endmodule

//--- bench/tbMacRef.svh
////////////////////
// Testbench helpers of the matrix MAC
// Reference model, LFSR stimulus source and the result compare tasks
////////////////////

`ifndef TB_MAC_REF_SVH
`define TB_MAC_REF_SVH

// Feedback mask of x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LfsrTaps = 32'h8020_0003;

// One step of a right-shifting Galois LFSR
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ LfsrTaps;
    end
    return state >> 1;
endfunction

// Takes count bits from a stream, one LFSR step per bit
task automatic drawBits(inout logic [31:0] state, input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], state[0]};
        state = lfsrStep(state);
    end
endtask

// Two's complement value of the low digits of an operand, upper bits ignored
function automatic int operandValue(input elem_t raw, input int digits);
    int width;
    int value;
    width = DigitBits * digits;
    value = 0;
    for (int i = 0; i < width; i++) begin
        if (raw[i] && i == width - 1) begin
            value = value - (1 << i);
        end else if (raw[i]) begin
            value = value + (1 << i);
        end
    end
    return value;
endfunction

// D = C + A*B with every sum wrapped to 32 bits
function automatic dMat_t refMac(input aMat_t a, input bMat_t b, input dMat_t c,
                                 input int sizeA, input int sizeB);
    dMat_t d;
    for (int r = 0; r < M; r++) begin
        for (int col = 0; col < N; col++) begin
            d[r][col] = c[r][col];
            for (int k = 0; k < K; k++) begin
                d[r][col] = d[r][col]
                          + acc_t'(operandValue(a[r][k], sizeA) * operandValue(b[k][col], sizeB));
            end
        end
    end
    return d;
endfunction

task automatic checkAcc(input acc_t got, input acc_t expected, input string what);
    checkCount++;
    if (got !== expected) begin
        errorCount++;
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
endtask

task automatic checkBit(input logic got, input logic expected, input string what);
    checkCount++;
    if (got !== expected) begin
        errorCount++;
        $display("** Error at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
endtask

`endif

//--- bench/tbMatMac.sv
////////////////////
// Testbench of the matrix MAC engine
// Random, unequal-width and extreme jobs under back-pressure against a reference
////////////////////

`timescale 1ns/100ps

module tbMatMac;
    import macPkg::*;

    localparam int M           = 2;
    localparam int N           = 2;
    localparam int K           = 2;
    localparam int MaxWidth    = 16;
    localparam int MaxDigits   = MaxWidth / DigitBits;
    localparam int ResetCycles = 16;
    localparam int NumJobs     = 17;
    // All digit pairs, the final column, and up to seven stalled cycles in Hold
    localparam int WorstJobCycles = MaxDigits * MaxDigits + 12;
    localparam int CycleLimit     = ResetCycles + NumJobs * WorstJobCycles + 100;

    typedef logic [MaxWidth-1:0] elem_t;
    typedef logic [M-1:0][K-1:0][MaxWidth-1:0] aMat_t;
    typedef logic [K-1:0][N-1:0][MaxWidth-1:0] bMat_t;
    typedef acc_t [M-1:0][N-1:0] dMat_t;

    logic        clk_i;
    logic        rst_ni;
    aMat_t       a_i;
    bMat_t       b_i;
    dMat_t       c_i;
    digitCount_t bitSizeA_i;
    digitCount_t bitSizeB_i;
    logic        valid_i;
    logic        ready_o;
    logic        valid_o;
    logic        ready_i;
    dMat_t       d_o;

    int          checkCount  = 0;
    int          errorCount  = 0;
    int          jobCount    = 0;
    int          resultCount = 0;
    int          cycleCount  = 0;
    int          inFlight;
    logic [31:0] dataLfsr    = 32'd88;
    logic [31:0] pressLfsr   = 32'd88;
    logic [31:0] stallBits;
    logic        pressure    = 1'b0;
    logic        holding     = 1'b0;
    dMat_t       heldD;
    dMat_t       expD;
    dMat_t       expQ [$];

    `include "tbMacRef.svh"

    matMacTop #(
        .M        (M),
        .N        (N),
        .K        (K),
        .MaxWidth (MaxWidth)
    ) u_matMacTop (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .a_i        (a_i),
        .b_i        (b_i),
        .c_i        (c_i),
        .bitSizeA_i (bitSizeA_i),
        .bitSizeB_i (bitSizeB_i),
        .valid_i    (valid_i),
        .ready_o    (ready_o),
        .valid_o    (valid_o),
        .ready_i    (ready_i),
        .d_o        (d_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic reportTotals();
        $display("Checks %0d, errors %0d, jobs %0d, results %0d",
                 checkCount, errorCount, jobCount, resultCount);
    endtask

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge clk_i);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CycleLimit);
        reportTotals();
        $display("Some tests failed");
        $finish;
    end

    // Back-pressure holds ready_i low for 0 to 7 cycles, then high for at least one
    initial begin
        ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (pressure) begin
                drawBits(pressLfsr, 3, stallBits);
                if (stallBits != 0) begin
                    ready_i = 1'b0;
                    repeat (stallBits) @(negedge clk_i);
                    ready_i = 1'b1;
                end
            end
        end
    end

    // Sees the pre-edge values, so results are taken before new jobs are queued
    always @(posedge clk_i) begin
        if (rst_ni) begin
            inFlight = expQ.size();
            checkBit(ready_o, inFlight == 0 || (valid_o && ready_i), "ready_o");
            if (inFlight == 0) begin
                checkBit(valid_o, 1'b0, "valid_o with no job");
            end
            if (holding) begin
                checkBit(valid_o, 1'b1, "valid_o under back-pressure");
                for (int r = 0; r < M; r++) begin
                    for (int c = 0; c < N; c++) begin
                        checkAcc(d_o[r][c], heldD[r][c],
                                 $sformatf("held d_o[%0d][%0d]", r, c));
                    end
                end
            end
            holding = valid_o && !ready_i;
            heldD   = d_o;
            if (valid_o && ready_i && inFlight == 0) begin
                errorCount++;
                $display("A result was handed out with no job outstanding at %0t", $time);
            end else if (valid_o && ready_i) begin
                expD = expQ.pop_front();
                resultCount++;
                for (int r = 0; r < M; r++) begin
                    for (int c = 0; c < N; c++) begin
                        checkAcc(d_o[r][c], expD[r][c], $sformatf("d_o[%0d][%0d]", r, c));
                    end
                end
            end
            if (valid_i && ready_o) begin
                expQ.push_back(refMac(a_i, b_i, c_i, int'(bitSizeA_i), int'(bitSizeB_i)));
            end
        end
    end

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic sendJob(input aMat_t aMat, input bMat_t bMat, input dMat_t cMat,
                           input int sizeA, input int sizeB);
        logic accepted;
        a_i        = aMat;
        b_i        = bMat;
        c_i        = cMat;
        bitSizeA_i = digitCount_t'(sizeA);
        bitSizeB_i = digitCount_t'(sizeB);
        valid_i    = 1'b1;
        accepted   = 1'b0;
        while (!accepted) begin
            @(posedge clk_i);
            accepted = ready_o;
        end
        jobCount++;
        @(negedge clk_i);
    endtask

    task automatic randomJob(input int sizeA, input int sizeB);
        aMat_t       aMat;
        bMat_t       bMat;
        dMat_t       cMat;
        logic [31:0] bits;
        for (int r = 0; r < M; r++) begin
            for (int k = 0; k < K; k++) begin
                drawBits(dataLfsr, DigitBits * sizeA, bits);
                aMat[r][k] = elem_t'(operandValue(elem_t'(bits), sizeA));
            end
        end
        for (int k = 0; k < K; k++) begin
            for (int c = 0; c < N; c++) begin
                drawBits(dataLfsr, DigitBits * sizeB, bits);
                bMat[k][c] = elem_t'(operandValue(elem_t'(bits), sizeB));
            end
        end
        for (int r = 0; r < M; r++) begin
            for (int c = 0; c < N; c++) begin
                drawBits(dataLfsr, 32, bits);
                cMat[r][c] = bits;
            end
        end
        sendJob(aMat, bMat, cMat, sizeA, sizeB);
    endtask

    task automatic extremeJob(input elem_t aVal, input elem_t bVal, input acc_t cVal,
                              input int sizeA, input int sizeB);
        aMat_t aMat;
        bMat_t bMat;
        dMat_t cMat;
        aMat = {(M * K){aVal}};
        bMat = {(K * N){bVal}};
        cMat = {(M * N){cVal}};
        sendJob(aMat, bMat, cMat, sizeA, sizeB);
    endtask

    initial begin
        logic [31:0] bits;
        int          sizeA;
        int          sizeB;
        rst_ni     = 1'b0;
        valid_i    = 1'b0;
        a_i        = '0;
        b_i        = '0;
        c_i        = '0;
        bitSizeA_i = digitCount_t'(1);
        bitSizeB_i = digitCount_t'(1);
        repeat (ResetCycles) @(negedge clk_i);
        rst_ni = 1'b1;

        // Idle state right after reset
        @(posedge clk_i);
        checkBit(valid_o, 1'b0, "valid_o after reset");
        checkBit(ready_o, 1'b1, "ready_o after reset");
        @(negedge clk_i);

        // valid_i stays high from here on, so every job follows the last directly
        repeat (3) randomJob(MaxDigits, MaxDigits);
        randomJob(1, MaxDigits);
        randomJob(MaxDigits, 1);
        randomJob(3, 6);
        randomJob(6, 3);
        randomJob(1, 1);

        extremeJob({1'b1, {(MaxWidth-1){1'b0}}}, {1'b1, {(MaxWidth-1){1'b0}}},
                   32'h7fff_ffff, MaxDigits, MaxDigits);
        extremeJob({1'b1, {(MaxWidth-1){1'b0}}}, {1'b0, {(MaxWidth-1){1'b1}}},
                   32'h8000_0000, MaxDigits, MaxDigits);
        extremeJob(elem_t'(-2), elem_t'(-2), 32'hffff_fff0, 1, 1);

        pressure = 1'b1;
        repeat (6) begin
            drawBits(dataLfsr, $clog2(MaxDigits), bits);
            sizeA = int'(bits) % MaxDigits + 1;
            drawBits(dataLfsr, $clog2(MaxDigits), bits);
            sizeB = int'(bits) % MaxDigits + 1;
            randomJob(sizeA, sizeB);
        end
        valid_i = 1'b0;

        while (resultCount < jobCount) begin
            @(negedge clk_i);
        end
        reportTotals();
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+bench
common/macPkg.sv
hw/sequencer/digitSequencer.sv
hw/multiplier/serialMult.sv
hw/multiplier/digitAdderTree.sv
hw/result/cellAccumulator.sv
hw/matMacTop.sv
bench/tbMatMac.sv

//--- Makefile
# Verilator build and run of the matrix MAC testbench

VERILATOR ?= verilator
TOP       ?= tbMatMac
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FLIST)) bench/tbMacRef.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

# Passes only if the log holds the pass line
check: run
	grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
